/* hw/usb_ctl_defines.svh */
`ifndef USB_CTL_DEFINES_SVH
`define USB_CTL_DEFINES_SVH

// IDs reported in the device descriptor
`define USB_VENDOR_ID   16'hFACE
`define USB_PRODUCT_ID  16'h0BDE

// String descriptor text, sent as UTF-16LE
`define USB_MANUF_STR   "Demo Maker"
`define USB_MANUF_LEN   10
`define USB_PRODUCT_STR "Pipe Zero"
`define USB_PRODUCT_LEN 9
`define USB_SERIAL_STR  "0001A"
`define USB_SERIAL_LEN  5

// Largest reply on endpoint 0
`define USB_MAX_PACKET  64

// Descriptor ROM address width
`define USB_ROM_ABITS   7

`endif

/* hw/usb_ctl_pkg.sv */
`default_nettype none

package usb_ctl_pkg;

  // Byte 0 of the packet sits in the low bits, so the multi-byte
  // fields come out little-endian as on the wire
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_fields_t;

  typedef union packed {
    logic [7:0][7:0] bytes;
    setup_fields_t   fields;
  } setup_pkt_u;

  typedef enum logic [7:0] {
    REQ_GET_STATUS        = 8'h00,
    REQ_SET_ADDRESS       = 8'h05,
    REQ_GET_DESCRIPTOR    = 8'h06,
    REQ_SET_CONFIGURATION = 8'h09,
    REQ_SET_INTERFACE     = 8'h0B
  } std_request_e;

  typedef enum logic [7:0] {
    DESC_DEVICE = 8'h01,
    DESC_CONFIG = 8'h02,
    DESC_STRING = 8'h03
  } desc_type_e;

  typedef struct packed {
    logic       set_addr;
    logic       set_conf;
    logic [7:0] value;
  } dev_cmd_t;

  typedef struct packed {
    logic [6:0] address;
    logic [2:0] conf_value;
    logic       enumerated;
    logic       configured;
  } dev_state_t;

endpackage

`default_nettype wire

/* hw/setup_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module setup_capture
  import usb_ctl_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       setup_valid_i,
  input  wire logic       setup_start_i,
  input  wire logic [7:0] setup_data_i,
  output logic            req_start_o,
  output setup_pkt_u      req_pkt_o
);

  logic [2:0] byte_cnt;
  logic [2:0] wr_idx;

  // A start byte always lands in slot 0
  assign wr_idx = setup_start_i ? 3'd0 : byte_cnt;

  always_ff @(posedge clock) begin
    if (reset) begin
      byte_cnt    <= 3'd0;
      req_start_o <= 1'b0;
    end else begin
      // Strobe follows the eighth byte by one cycle
      req_start_o <= setup_valid_i && (wr_idx == 3'd7);
      if (setup_valid_i) begin
        byte_cnt <= wr_idx + 3'd1;
      end else if (setup_start_i) begin
        byte_cnt <= 3'd0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (setup_valid_i) begin
      req_pkt_o.bytes[wr_idx] <= setup_data_i;
    end
  end

  // The packet must hold still while the handler samples it
  assert property (@(posedge clock) disable iff (reset)
    setup_valid_i && (wr_idx == 3'd7) |=> !setup_valid_i)
    else $error("setup byte arrived during the request strobe");

endmodule

`default_nettype wire

/* hw/descriptor_rom.sv */
`timescale 1ns/10ps
`default_nettype none
`include "usb_ctl_defines.svh"

module descriptor_rom
  import usb_ctl_pkg::*;
(
  input  wire desc_type_e                desc_type_i,
  input  wire logic [7:0]                desc_index_i,
  output logic [`USB_ROM_ABITS-1:0]      start_addr_o,
  input  wire logic [`USB_ROM_ABITS-1:0] rd_addr_i,
  output logic [7:0]                     rd_data_o,
  output logic                           rd_last_o
);

  localparam int AW    = `USB_ROM_ABITS;
  localparam int DEPTH = 1 << AW;

  // Table layout
  localparam int DEV_START   = 0;
  localparam int CONF_START  = 18;
  localparam int LANG_START  = 36;
  localparam int MANUF_START = 40;
  localparam int PROD_START  = MANUF_START + 2 + 2 * `USB_MANUF_LEN;
  localparam int SER_START   = PROD_START + 2 + 2 * `USB_PRODUCT_LEN;
  localparam int STAT_START  = SER_START + 2 + 2 * `USB_SERIAL_LEN;
  localparam int TABLE_LEN   = STAT_START + 6;

  localparam logic [15:0] VID = `USB_VENDOR_ID;
  localparam logic [15:0] PID = `USB_PRODUCT_ID;

  typedef logic [DEPTH-1:0][7:0] rom_t;

  // USB 2.0, vendor class, one configuration, strings 1 to 3
  localparam logic [0:17][7:0] DEV_DESC = '{
    8'd18, DESC_DEVICE, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'(`USB_MAX_PACKET),
    VID[7:0], VID[15:8], PID[7:0], PID[15:8],
    8'h00, 8'h01, 8'h01, 8'h02, 8'h03, 8'h01
  };

  // Configuration 1, bus powered at 100 mA, one interface with no endpoints
  localparam logic [0:17][7:0] CONF_DESC = '{
    8'd9, DESC_CONFIG, 8'd18, 8'd0, 8'd1, 8'd1, 8'd0, 8'h80, 8'd50,
    8'd9, 8'h04, 8'd0, 8'd0, 8'd0, 8'hFF, 8'd0, 8'd0, 8'd0
  };

  // English (US) only
  localparam logic [0:3][7:0] LANG_DESC = '{8'd4, DESC_STRING, 8'h09, 8'h04};

  function automatic rom_t put_string(rom_t rom, int start, logic [255:0] text, int len);
    rom[start]     = 8'(2 + 2 * len);
    rom[start + 1] = DESC_STRING;
    for (int i = 0; i < len; i++) begin
      rom[start + 2 + 2 * i] = text[8 * (len - i) - 1 -: 8];
      rom[start + 3 + 2 * i] = 8'h00;
    end
    return rom;
  endfunction

  function automatic rom_t build_rom();
    rom_t rom;
    // Status words stay all zero
    rom = '0;
    for (int i = 0; i < 18; i++) begin
      rom[DEV_START + i]  = DEV_DESC[i];
      rom[CONF_START + i] = CONF_DESC[i];
    end
    for (int i = 0; i < 4; i++) begin
      rom[LANG_START + i] = LANG_DESC[i];
    end
    rom = put_string(rom, MANUF_START, `USB_MANUF_STR, `USB_MANUF_LEN);
    rom = put_string(rom, PROD_START, `USB_PRODUCT_STR, `USB_PRODUCT_LEN);
    rom = put_string(rom, SER_START, `USB_SERIAL_STR, `USB_SERIAL_LEN);
    return rom;
  endfunction

  function automatic logic [DEPTH-1:0] build_last();
    logic [DEPTH-1:0] marks;
    marks = '0;
    marks[CONF_START - 1]  = 1'b1;
    marks[LANG_START - 1]  = 1'b1;
    marks[MANUF_START - 1] = 1'b1;
    marks[PROD_START - 1]  = 1'b1;
    marks[SER_START - 1]   = 1'b1;
    marks[STAT_START - 1]  = 1'b1;
    // Each status word is a reply of its own
    marks[STAT_START + 1]  = 1'b1;
    marks[STAT_START + 3]  = 1'b1;
    marks[TABLE_LEN - 1]   = 1'b1;
    return marks;
  endfunction

  localparam rom_t             ROM  = build_rom();
  localparam logic [DEPTH-1:0] LAST = build_last();

  if (TABLE_LEN > DEPTH) begin : g_size_check
    $error("descriptor table does not fit the ROM address range");
  end

  always_comb begin
    case (desc_type_i)
      DESC_DEVICE: start_addr_o = AW'(DEV_START);
      DESC_CONFIG: start_addr_o = AW'(CONF_START);
      DESC_STRING: begin
        case (desc_index_i)
          8'd0:    start_addr_o = AW'(LANG_START);
          8'd1:    start_addr_o = AW'(MANUF_START);
          8'd2:    start_addr_o = AW'(PROD_START);
          default: start_addr_o = AW'(SER_START);
        endcase
      end
      // Anything else is a status read with the recipient as index
      default: begin
        case (desc_index_i)
          8'd0:    start_addr_o = AW'(STAT_START);
          8'd1:    start_addr_o = AW'(STAT_START + 2);
          default: start_addr_o = AW'(STAT_START + 4);
        endcase
      end
    endcase
  end

  assign rd_data_o = ROM[rd_addr_i];
  assign rd_last_o = LAST[rd_addr_i];

endmodule

`default_nettype wire

/* hw/axis_chop.sv */
`timescale 1ns/10ps
`default_nettype none

module axis_chop (
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       load_i,
  input  wire logic [6:0] length_i,
  input  wire logic       s_valid_i,
  output logic            s_ready_o,
  input  wire logic       s_last_i,
  input  wire logic [7:0] s_data_i,
  output logic            m_tvalid_o,
  input  wire logic       m_tready_i,
  output logic            m_tlast_o,
  output logic [7:0]      m_tdata_o
);

  logic [6:0] remain;
  logic       closed;
  logic       take;
  logic       cut;

  // Register is free when empty or draining this cycle
  assign s_ready_o = !load_i && !closed && (!m_tvalid_o || m_tready_i);
  assign take      = s_valid_i && s_ready_o;
  assign cut       = s_last_i || (remain == 7'd1);

  always_ff @(posedge clock) begin
    if (reset) begin
      m_tvalid_o <= 1'b0;
      closed     <= 1'b1;
      remain     <= 7'd0;
    end else if (load_i) begin
      // New request drops whatever was left of the old reply
      m_tvalid_o <= 1'b0;
      closed     <= (length_i == 7'd0);
      remain     <= length_i;
    end else if (take) begin
      m_tvalid_o <= 1'b1;
      closed     <= cut;
      remain     <= remain - 7'd1;
    end else if (m_tready_i) begin
      m_tvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      m_tdata_o <= s_data_i;
      m_tlast_o <= cut;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    m_tvalid_o && !m_tready_i && !load_i |=> m_tvalid_o && $stable(m_tdata_o))
    else $error("output byte changed while stalled");

endmodule

`default_nettype wire

/* hw/ctl_pipe0.sv */
`timescale 1ns/10ps
`default_nettype none
`include "usb_ctl_defines.svh"

module ctl_pipe0
  import usb_ctl_pkg::*;
(
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire logic                      select_i,
  input  wire logic                      req_start_i,
  input  wire setup_pkt_u                req_pkt_i,
  output logic                           done_o,
  output logic                           error_o,
  output desc_type_e                     desc_type_o,
  output logic [7:0]                     desc_index_o,
  input  wire logic [`USB_ROM_ABITS-1:0] rom_start_i,
  output logic [`USB_ROM_ABITS-1:0]      rd_addr_o,
  input  wire logic                      rd_last_i,
  output logic                           chop_load_o,
  output logic [6:0]                     chop_length_o,
  output logic                           s_valid_o,
  input  wire logic                      s_ready_i,
  output dev_cmd_t                       cmd_o
);

  setup_fields_t req;
  logic          strobe;
  logic          std_w;
  logic          get_w;
  logic          start_q;
  logic          std_q;
  logic          get_q;
  std_request_e  code_q;
  logic [7:0]    value_q;
  logic          set_ok;
  logic          stage2;

  assign req    = req_pkt_i.fields;
  assign strobe = req_start_i && select_i;

  // Class and vendor requests fail stage 1 and end in error
  assign std_w = (req.bm_request_type[6:5] == 2'b00);

  // Device-to-host requests that the ROM can answer
  always_comb begin
    get_w = 1'b0;
    if (std_w && req.bm_request_type[7]) begin
      if (req.b_request == REQ_GET_STATUS) begin
        get_w = (req.bm_request_type[1:0] != 2'b11);
      end else if (req.b_request == REQ_GET_DESCRIPTOR) begin
        get_w = (req.w_value[15:8] == DESC_DEVICE) ||
                (req.w_value[15:8] == DESC_CONFIG) ||
                (req.w_value[15:8] == DESC_STRING);
      end
    end
  end

  // ROM lookup runs on the raw packet so the address is ready at the strobe
  always_comb begin
    if (req.b_request == REQ_GET_STATUS) begin
      desc_type_o  = desc_type_e'(8'h00);
      desc_index_o = {6'd0, req.bm_request_type[1:0]};
    end else begin
      desc_type_o  = desc_type_e'(req.w_value[15:8]);
      desc_index_o = req.w_value[7:0];
    end
  end

  assign chop_load_o   = strobe;
  assign chop_length_o = (req.w_length > 16'(`USB_MAX_PACKET)) ?
                         7'(`USB_MAX_PACKET) : req.w_length[6:0];

  assign s_valid_o = get_q;

  // Stage 2 qualifies the set requests
  assign set_ok = std_q && ((code_q == REQ_SET_ADDRESS) ||
                            (code_q == REQ_SET_CONFIGURATION) ||
                            (code_q == REQ_SET_INTERFACE));
  assign stage2 = start_q && select_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= 1'b0;
      get_q   <= 1'b0;
      done_o  <= 1'b0;
      error_o <= 1'b0;
      cmd_o   <= '0;
    end else begin
      start_q        <= strobe;
      done_o         <= stage2 && set_ok;
      cmd_o.set_addr <= stage2 && std_q && (code_q == REQ_SET_ADDRESS);
      cmd_o.set_conf <= stage2 && std_q && (code_q == REQ_SET_CONFIGURATION);
      cmd_o.value    <= value_q;

      // A reply cut short by the chopper parks here until select drops
      if (strobe) begin
        get_q <= get_w;
      end else if (!select_i || (get_q && s_ready_i && rd_last_i)) begin
        get_q <= 1'b0;
      end

      if (!select_i) begin
        error_o <= 1'b0;
      end else if (start_q) begin
        error_o <= !(get_q || set_ok);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (strobe) begin
      std_q     <= std_w;
      code_q    <= std_request_e'(req.b_request);
      value_q   <= req.w_value[7:0];
      rd_addr_o <= rom_start_i;
    end else if (get_q && s_ready_i) begin
      // Walk only when the chopper takes the byte
      rd_addr_o <= rd_addr_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/usb_dev_state.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_dev_state
  import usb_ctl_pkg::*;
(
  input  wire logic     clock,
  input  wire logic     reset,
  input  wire dev_cmd_t cmd_i,
  output dev_state_t    dev_state_o
);

  always_ff @(posedge clock) begin
    if (reset) begin
      dev_state_o <= '0;
    end else begin
      // Address goes live right away since there is no status stage
      if (cmd_i.set_addr) begin
        dev_state_o.address    <= cmd_i.value[6:0];
        dev_state_o.enumerated <= 1'b1;
      end
      if (cmd_i.set_conf) begin
        dev_state_o.conf_value <= cmd_i.value[2:0];
        dev_state_o.configured <= 1'b1;
      end
    end
  end

  // The handler decodes one request at a time
  assert property (@(posedge clock) disable iff (reset)
    !(cmd_i.set_addr && cmd_i.set_conf))
    else $error("address and configuration commands fired together");

endmodule

`default_nettype wire

/* hw/usb_ctl_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "usb_ctl_defines.svh"

module usb_ctl_top
  import usb_ctl_pkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire logic       select_i,
  input  wire logic       setup_valid_i,
  input  wire logic       setup_start_i,
  input  wire logic [7:0] setup_data_i,
  output logic            m_tvalid_o,
  input  wire logic       m_tready_i,
  output logic            m_tlast_o,
  output logic [7:0]      m_tdata_o,
  output logic            done_o,
  output logic            error_o,
  output dev_state_t      dev_state_o
);

  logic                     req_start;
  setup_pkt_u               req_pkt;
  desc_type_e               desc_type;
  logic [7:0]               desc_index;
  logic [`USB_ROM_ABITS-1:0] rom_start;
  logic [`USB_ROM_ABITS-1:0] rd_addr;
  logic [7:0]               rd_data;
  logic                     rd_last;
  logic                     chop_load;
  logic [6:0]               chop_length;
  logic                     s_valid;
  logic                     s_ready;
  dev_cmd_t                 dev_cmd;

  setup_capture u_capture (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid_i),
    .setup_start_i (setup_start_i),
    .setup_data_i  (setup_data_i),
    .req_start_o   (req_start),
    .req_pkt_o     (req_pkt)
  );

  ctl_pipe0 u_pipe0 (
    .clock         (clock),
    .reset         (reset),
    .select_i      (select_i),
    .req_start_i   (req_start),
    .req_pkt_i     (req_pkt),
    .done_o        (done_o),
    .error_o       (error_o),
    .desc_type_o   (desc_type),
    .desc_index_o  (desc_index),
    .rom_start_i   (rom_start),
    .rd_addr_o     (rd_addr),
    .rd_last_i     (rd_last),
    .chop_load_o   (chop_load),
    .chop_length_o (chop_length),
    .s_valid_o     (s_valid),
    .s_ready_i     (s_ready),
    .cmd_o         (dev_cmd)
  );

  descriptor_rom u_rom (
    .desc_type_i  (desc_type),
    .desc_index_i (desc_index),
    .start_addr_o (rom_start),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data),
    .rd_last_o    (rd_last)
  );

  // ROM bytes feed the chopper directly while the handler paces them
  axis_chop u_chop (
    .clock      (clock),
    .reset      (reset),
    .load_i     (chop_load),
    .length_i   (chop_length),
    .s_valid_i  (s_valid),
    .s_ready_o  (s_ready),
    .s_last_i   (rd_last),
    .s_data_i   (rd_data),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o)
  );

  usb_dev_state u_state (
    .clock       (clock),
    .reset       (reset),
    .cmd_i       (dev_cmd),
    .dev_state_o (dev_state_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_usb_ctl_model.svh */
`ifndef TB_USB_CTL_MODEL_SVH
`define TB_USB_CTL_MODEL_SVH

`include "usb_ctl_defines.svh"

typedef logic [7:0] byte_q_t[$];

// String descriptor with the text as UTF-16LE after the two header bytes
function automatic byte_q_t string_bytes(string text);
  byte_q_t q;
  q.push_back(8'(2 + 2 * text.len()));
  q.push_back(8'h03);
  for (int i = 0; i < text.len(); i++) begin
    q.push_back(text[i]);
    q.push_back(8'h00);
  end
  return q;
endfunction

// Type 8'h00 stands for a GET_STATUS reply
function automatic byte_q_t expected_desc(logic [7:0] dtype, logic [7:0] index,
                                          logic [15:0] w_length);
  byte_q_t     full;
  byte_q_t     q;
  logic [15:0] vid;
  logic [15:0] pid;
  int          n;
  vid = `USB_VENDOR_ID;
  pid = `USB_PRODUCT_ID;
  case (dtype)
    8'h01: full = {8'd18, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'(`USB_MAX_PACKET),
                   vid[7:0], vid[15:8], pid[7:0], pid[15:8],
                   8'h00, 8'h01, 8'h01, 8'h02, 8'h03, 8'h01};
    // Configuration followed by its single interface
    8'h02: full = {8'd9, 8'h02, 8'd18, 8'd0, 8'd1, 8'd1, 8'd0, 8'h80, 8'd50,
                   8'd9, 8'h04, 8'd0, 8'd0, 8'd0, 8'hFF, 8'd0, 8'd0, 8'd0};
    8'h03: begin
      case (index)
        8'd0:    full = {8'd4, 8'h03, 8'h09, 8'h04};
        8'd1:    full = string_bytes(`USB_MANUF_STR);
        8'd2:    full = string_bytes(`USB_PRODUCT_STR);
        default: full = string_bytes(`USB_SERIAL_STR);
      endcase
    end
    8'h00:   full = {8'h00, 8'h00};
    default: full = {};
  endcase
  n = full.size();
  if (w_length < n) n = w_length;
  if (n > `USB_MAX_PACKET) n = `USB_MAX_PACKET;
  for (int i = 0; i < n; i++) begin
    q.push_back(full[i]);
  end
  return q;
endfunction

// Only standard requests touch the device state
function automatic dev_state_t expected_state(dev_state_t cur, setup_fields_t req);
  dev_state_t nxt;
  nxt = cur;
  if (req.bm_request_type[6:5] == 2'b00) begin
    if (req.b_request == REQ_SET_ADDRESS) begin
      nxt.address    = req.w_value[6:0];
      nxt.enumerated = 1'b1;
    end else if (req.b_request == REQ_SET_CONFIGURATION) begin
      nxt.conf_value = req.w_value[2:0];
      nxt.configured = 1'b1;
    end
  end
  return nxt;
endfunction

`endif

/* testbench/tb_usb_ctl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "usb_ctl_defines.svh"

module tb_usb_ctl
  import usb_ctl_pkg::*;
();

  `include "tb_usb_ctl_model.svh"

  localparam time CLK_PERIOD  = 100;
  localparam int  NUM_TESTS   = 15;
  localparam int  TEST_CYCLES = 2000;

  logic       clock;
  logic       reset;
  logic       select_i;
  logic       setup_valid_i;
  logic       setup_start_i;
  logic [7:0] setup_data_i;
  logic       m_tvalid_o;
  logic       m_tready_i;
  logic       m_tlast_o;
  logic [7:0] m_tdata_o;
  logic       done_o;
  logic       error_o;
  dev_state_t dev_state_o;

  integer     seed;
  logic       random_ready;
  byte_q_t    rx_q;
  int         last_cnt;
  int         last_pos;
  int         errors;
  int         test_errs;
  int         tests_run;
  int         tests_failed;
  dev_state_t model_state;

  usb_ctl_top dut0 (
    .clock         (clock),
    .reset         (reset),
    .select_i      (select_i),
    .setup_valid_i (setup_valid_i),
    .setup_start_i (setup_start_i),
    .setup_data_i  (setup_data_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tlast_o     (m_tlast_o),
    .m_tdata_o     (m_tdata_o),
    .done_o        (done_o),
    .error_o       (error_o),
    .dev_state_o   (dev_state_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // A random draw every cycle keeps the sequence fixed for a given seed
  initial begin
    logic r;
    m_tready_i = 1'b1;
    forever begin
      @(posedge clock);
      #10;
      r = (($random(seed) & 3) != 0);
      m_tready_i = random_ready ? r : 1'b1;
    end
  end

  // Collect accepted bytes at the falling edge
  always @(negedge clock) begin
    if (!reset && m_tvalid_o && m_tready_i) begin
      rx_q.push_back(m_tdata_o);
      if (m_tlast_o) begin
        last_cnt++;
        if (last_cnt == 1) last_pos = rx_q.size();
      end
    end
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog expired: tests did not finish within %0d cycles",
             NUM_TESTS * TEST_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic next_cycle();
    @(posedge clock);
    #10;
  endtask

  task automatic report_error(string msg);
    $display("** Error at %0t: %s", $time, msg);
    errors++;
    test_errs++;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("%-26s ok", name);
    end else begin
      tests_failed++;
      $display("%-26s failed, %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic check_stream(string name, byte_q_t exp_q, byte_q_t got_q);
    if (got_q.size() != exp_q.size())
      report_error($sformatf("%s: expected %0d bytes, got %0d", name, exp_q.size(),
                             got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      if (got_q[i] !== exp_q[i])
        report_error($sformatf("%s: byte %0d expected %02h, got %02h", name, i,
                               exp_q[i], got_q[i]));
    end
  endtask

  task automatic check_state(string name, dev_state_t got, dev_state_t exp);
    if (got !== exp)
      report_error($sformatf("%s: expected addr %02h conf %0d flags %b%b, got %02h %0d %b%b",
                             name, exp.address, exp.conf_value, exp.enumerated,
                             exp.configured, got.address, got.conf_value,
                             got.enumerated, got.configured));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) report_error($sformatf("%s: expected %b, got %b", name, exp, got));
  endtask

  function automatic setup_pkt_u make_pkt(logic [7:0] bmrt, logic [7:0] breq,
                                          logic [15:0] wvalue, logic [15:0] wlength);
    setup_pkt_u pkt;
    pkt.fields = '{w_length: wlength, w_index: 16'h0000, w_value: wvalue,
                   b_request: breq, bm_request_type: bmrt};
    return pkt;
  endfunction

  task automatic send_setup(setup_pkt_u pkt);
    select_i = 1'b1;
    for (int i = 0; i < 8; i++) begin
      setup_valid_i = 1'b1;
      setup_start_i = (i == 0);
      setup_data_i  = pkt.bytes[i];
      next_cycle();
    end
    setup_valid_i = 1'b0;
    setup_start_i = 1'b0;
  endtask

  task automatic run_get(string name, setup_pkt_u pkt, logic [7:0] dtype,
                         logic [7:0] dindex);
    byte_q_t exp_q;
    int      cycles;
    exp_q = expected_desc(dtype, dindex, pkt.fields.w_length);
    rx_q.delete();
    last_cnt = 0;
    last_pos = 0;
    send_setup(pkt);
    cycles = 0;
    while (last_cnt == 0 && cycles < TEST_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    if (last_cnt == 0) begin
      $display("%s: no byte with m_tlast_o arrived within %0d cycles", name, TEST_CYCLES);
      errors++;
      test_errs++;
    end
    // Trailing bytes after the last one would show up here
    repeat (4) @(negedge clock);
    check_stream(name, exp_q, rx_q);
    if (last_cnt != 1 || last_pos != exp_q.size())
      report_error($sformatf("%s: m_tlast_o seen %0d times, first on byte %0d of %0d",
                             name, last_cnt, last_pos, exp_q.size()));
    check_flag({name, " error_o"}, error_o, 1'b0);
    next_cycle();
    select_i = 1'b0;
    next_cycle();
    end_test(name);
  endtask

  task automatic run_set(string name, setup_pkt_u pkt, logic exp_done);
    dev_state_t exp_state;
    int         cycles;
    logic       got_done;
    logic       got_error;
    exp_state = expected_state(model_state, pkt.fields);
    send_setup(pkt);
    cycles    = 0;
    got_done  = 1'b0;
    got_error = 1'b0;
    while (!got_done && !got_error && cycles < TEST_CYCLES) begin
      @(negedge clock);
      got_done  = done_o;
      got_error = error_o;
      cycles++;
    end
    if (!got_done && !got_error) begin
      $display("%s: neither done_o nor error_o rose within %0d cycles", name, TEST_CYCLES);
      errors++;
      test_errs++;
    end
    check_flag({name, " done_o"}, got_done, exp_done);
    check_flag({name, " error_o"}, got_error, !exp_done);
    @(negedge clock);
    check_flag({name, " done_o pulse"}, done_o, 1'b0);
    check_flag({name, " error_o held"}, error_o, !exp_done);
    // New state shows on the cycle after done_o
    check_state(name, dev_state_o, exp_state);
    model_state = exp_state;
    next_cycle();
    select_i = 1'b0;
    next_cycle();
    @(negedge clock);
    check_flag({name, " error_o after select"}, error_o, 1'b0);
    next_cycle();
    end_test(name);
  endtask

  initial begin
    seed          = 32'hca8f;
    random_ready  = 1'b0;
    errors        = 0;
    test_errs     = 0;
    tests_run     = 0;
    tests_failed  = 0;
    model_state   = '0;
    reset         = 1'b1;
    select_i      = 1'b0;
    setup_valid_i = 1'b0;
    setup_start_i = 1'b0;
    setup_data_i  = 8'h00;
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b0;
    @(negedge clock);
    check_flag("m_tvalid_o after reset", m_tvalid_o, 1'b0);
    check_flag("done_o after reset", done_o, 1'b0);
    check_flag("error_o after reset", error_o, 1'b0);
    check_state("state after reset", dev_state_o, '0);
    end_test("reset values");
    next_cycle();

    run_get("device descriptor", make_pkt(8'h80, REQ_GET_DESCRIPTOR, 16'h0100, 16'd18),
            DESC_DEVICE, 8'd0);
    run_get("device, wLength 64", make_pkt(8'h80, REQ_GET_DESCRIPTOR, 16'h0100, 16'd64),
            DESC_DEVICE, 8'd0);
    run_get("config, wLength 9", make_pkt(8'h80, REQ_GET_DESCRIPTOR, 16'h0200, 16'd9),
            DESC_CONFIG, 8'd0);
    for (int i = 0; i < 4; i++) begin
      run_get($sformatf("string %0d", i),
              make_pkt(8'h80, REQ_GET_DESCRIPTOR, {8'h03, 8'(i)}, 16'd255),
              DESC_STRING, 8'(i));
    end

    // Stall the output at random
    random_ready = 1'b1;
    run_get("config, random ready", make_pkt(8'h80, REQ_GET_DESCRIPTOR, 16'h0200, 16'd255),
            DESC_CONFIG, 8'd0);
    run_get("string 2, random ready", make_pkt(8'h80, REQ_GET_DESCRIPTOR, 16'h0302, 16'd255),
            DESC_STRING, 8'd2);
    random_ready = 1'b0;

    run_set("set address 0x2A", make_pkt(8'h00, REQ_SET_ADDRESS, 16'h002A, 16'd0), 1'b1);
    run_set("set configuration 1", make_pkt(8'h00, REQ_SET_CONFIGURATION, 16'h0001, 16'd0),
            1'b1);
    // SET_FEATURE is standard but not served
    run_set("unsupported request", make_pkt(8'h00, 8'h03, 16'h0001, 16'd0), 1'b0);
    run_set("class request", make_pkt(8'h21, 8'h09, 16'h0005, 16'd0), 1'b0);
    run_get("get status", make_pkt(8'h80, REQ_GET_STATUS, 16'h0000, 16'd2), 8'h00, 8'd0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
+incdir+testbench
hw/usb_ctl_pkg.sv
hw/setup_capture.sv
hw/descriptor_rom.sv
hw/axis_chop.sv
hw/ctl_pipe0.sv
hw/usb_dev_state.sv
hw/usb_ctl_top.sv
testbench/tb_usb_ctl.sv

/* Bender.yml */
package:
  name: usb_ctl

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/usb_ctl_pkg.sv
      - hw/setup_capture.sv
      - hw/descriptor_rom.sv
      - hw/axis_chop.sv
      - hw/ctl_pipe0.sv
      - hw/usb_dev_state.sv
      - hw/usb_ctl_top.sv
  - target: test
    include_dirs:
      - hw
      - testbench
    files:
      - testbench/tb_usb_ctl.sv
